// File: Makefile
TOP := tb_rf_exe_controller

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f build.f

sim:
	verilator --binary --timing --top-module $(TOP) -f build.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	@if grep -q "=== FAIL ===" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" sim.log || (echo "Simulation ended early"; exit 1)

clean:
	rm -rf obj_dir sim.log

// File: build.f
+incdir+tests
design/rf_exe_pkg.sv
design/instr_decoder.sv
design/cop_config_regs.sv
design/issue_hold_ctrl.sv
design/exe_issue_reg.sv
design/rf_exe_controller.sv
tests/tb_rf_exe_controller.sv

// File: design/cop_config_regs.sv
`timescale 1ns/1ps
`default_nettype none

module cop_config_regs #(
    parameter int cop_count = 3
) (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   cfg_write,
    input  wire rf_exe_pkg::cfg_t cfg_data,
    output rf_exe_pkg::cfg_t      cfg
);

    ////////////////////////////////////////////////////////////
    // Usable mask, one bit per implemented coprocessor
    ////////////////////////////////////////////////////////////

    localparam logic [4:0] usable_limit = 5'd1 << cop_count;
    localparam logic [3:0] usable_mask  = 4'(usable_limit - 5'd1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg <= '0;                          // User mode, nothing usable
        end else if (cfg_write) begin
            cfg.kernel_mode <= cfg_data.kernel_mode;
            cfg.cop_usable  <= cfg_data.cop_usable & usable_mask;
        end
    end

endmodule

`default_nettype wire

// File: design/exe_issue_reg.sv
`timescale 1ns/1ps
`default_nettype none

module exe_issue_reg (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          load,
    input  wire                          kill,
    input  wire rf_exe_pkg::exe_bundle_t bundle_in,
    output logic                         exe_valid,
    output rf_exe_pkg::exe_bundle_t      exe_out
);

    logic capture;

    assign capture = load & ~kill;

    ////////////////////////////////////////////////////////////
    // RF to EXE register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exe_valid <= 1'b0;
            exe_out   <= '0;
        end else if (capture) begin
            exe_valid <= 1'b1;
            exe_out   <= bundle_in;
        end else begin
            // Bubble, all selects back to none
            exe_valid <= 1'b0;
            exe_out   <= '0;
        end
    end

endmodule

`default_nettype wire

// File: design/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder #(
    parameter int cop_count = 3
) (
    input  wire rf_exe_pkg::instr_t instr,
    input  wire rf_exe_pkg::cfg_t   cfg,
    output rf_exe_pkg::exe_ctrl_t   ctrl,
    output logic                    muldiv
);

    logic [5:0]           opcode;
    logic [5:0]           funct;
    rf_exe_pkg::reg_idx_t rs;
    rf_exe_pkg::reg_idx_t rt;
    logic [1:0]           cop_sel;

    assign opcode  = instr[rf_exe_pkg::opcode_hi:rf_exe_pkg::opcode_lo];
    assign funct   = instr[rf_exe_pkg::funct_hi:rf_exe_pkg::funct_lo];
    assign rs      = instr[rf_exe_pkg::rs_hi:rf_exe_pkg::rs_lo];
    assign rt      = instr[rf_exe_pkg::rt_hi:rf_exe_pkg::rt_lo];
    assign cop_sel = opcode[1:0];

    // HI/LO group, also covers mfhi and mflo
    assign muldiv = (opcode == 6'b000000) && (funct[5:4] == 2'b01);

    always_comb begin
        ctrl = '0;

        ////////////////////////////////////////////////////////////
        // ALU
        ////////////////////////////////////////////////////////////
        casez ({opcode, funct})
            12'b001111_??????: ctrl.alu_op = rf_exe_pkg::alu_lui;
            12'b00100?_??????: ctrl.alu_op = rf_exe_pkg::alu_add;  // Addi, addiu
            12'b00101?_??????: ctrl.alu_op = rf_exe_pkg::alu_slt;  // Slti, sltiu
            12'b001100_??????: ctrl.alu_op = rf_exe_pkg::alu_and;
            12'b001101_??????: ctrl.alu_op = rf_exe_pkg::alu_or;
            12'b001110_??????: ctrl.alu_op = rf_exe_pkg::alu_xor;
            12'b000000_10000?: ctrl.alu_op = rf_exe_pkg::alu_add;  // Add, addu
            12'b000000_10001?: ctrl.alu_op = rf_exe_pkg::alu_sub;  // Sub, subu
            12'b000000_100100: ctrl.alu_op = rf_exe_pkg::alu_and;
            12'b000000_100101: ctrl.alu_op = rf_exe_pkg::alu_or;
            12'b000000_100110: ctrl.alu_op = rf_exe_pkg::alu_xor;
            12'b000000_100111: ctrl.alu_op = rf_exe_pkg::alu_nor;
            12'b000000_10101?: ctrl.alu_op = rf_exe_pkg::alu_slt;  // Slt, sltu
            default: ;
        endcase

        casez ({opcode, funct})
            12'b001000_??????,
            12'b001010_??????,
            12'b000000_100000,
            12'b000000_100010,
            12'b000000_101010: ctrl.signed_alu = 1'b1;
            default: ;
        endcase

        ////////////////////////////////////////////////////////////
        // Jumps and branches
        ////////////////////////////////////////////////////////////
        casez ({opcode, rt, funct})
            17'b00001?_?????_??????: ctrl.branch_op = rf_exe_pkg::branch_jump;  // J, jal
            17'b000000_?????_00100?: ctrl.branch_op = rf_exe_pkg::branch_jump_reg;
            17'b000100_?????_??????: ctrl.branch_op = rf_exe_pkg::branch_eq;
            17'b000101_?????_??????: ctrl.branch_op = rf_exe_pkg::branch_neq;
            17'b000110_?????_??????: ctrl.branch_op = rf_exe_pkg::branch_lez;
            17'b000111_?????_??????: ctrl.branch_op = rf_exe_pkg::branch_gz;
            17'b000001_?0000_??????: ctrl.branch_op = rf_exe_pkg::branch_lz;  // Bltz, bltzal
            17'b000001_?0001_??????: ctrl.branch_op = rf_exe_pkg::branch_gz;  // Bgez, bgezal
            default: ;
        endcase

        // Loads and stores
        case (opcode)
            6'b100000: ctrl.load_op  = rf_exe_pkg::load_sbyte;
            6'b100100: ctrl.load_op  = rf_exe_pkg::load_ubyte;
            6'b100001: ctrl.load_op  = rf_exe_pkg::load_shalf;
            6'b100101: ctrl.load_op  = rf_exe_pkg::load_uhalf;
            6'b100011: ctrl.load_op  = rf_exe_pkg::load_word;
            6'b100010: ctrl.load_op  = rf_exe_pkg::load_lwl;
            6'b100110: ctrl.load_op  = rf_exe_pkg::load_lwr;
            6'b101000: ctrl.store_op = rf_exe_pkg::store_byte;
            6'b101001: ctrl.store_op = rf_exe_pkg::store_half;
            6'b101011: ctrl.store_op = rf_exe_pkg::store_word;
            default: ;
        endcase
        ctrl.load  = (opcode[5:3] == 3'b100);
        ctrl.store = (opcode[5:3] == 3'b101);

        ////////////////////////////////////////////////////////////
        // Shifter and SPECIAL strobes
        ////////////////////////////////////////////////////////////
        if (opcode == 6'b000000) begin
            case (funct)
                6'b000000: ctrl.shift_op = rf_exe_pkg::shift_sll;
                6'b000010: ctrl.shift_op = rf_exe_pkg::shift_srl;
                6'b000011: ctrl.shift_op = rf_exe_pkg::shift_sra;
                6'b000100: ctrl.shift_op = rf_exe_pkg::shift_sllv;
                6'b000110: ctrl.shift_op = rf_exe_pkg::shift_srlv;
                6'b000111: ctrl.shift_op = rf_exe_pkg::shift_srav;
                6'b010001: ctrl.mthi     = 1'b1;
                6'b010011: ctrl.mtlo     = 1'b1;
                6'b011000: ctrl.mult     = 1'b1;
                6'b011001: ctrl.multu    = 1'b1;
                6'b011010: ctrl.div      = 1'b1;
                6'b011011: ctrl.divu     = 1'b1;
                default: ;
            endcase
            ctrl.shift_imm = (funct[5:2] == 4'b0000) && (funct[1:0] != 2'b01);
        end

        // Result source
        casez ({opcode, rt, funct})
            17'b000011_?????_??????: ctrl.result_sel = rf_exe_pkg::result_pc;    // Jal
            17'b001???_?????_??????: ctrl.result_sel = rf_exe_pkg::result_alu;
            17'b100???_?????_??????: ctrl.result_sel = rf_exe_pkg::result_load;
            17'b000000_?????_000???: ctrl.result_sel = rf_exe_pkg::result_shift;
            17'b000000_?????_001001: ctrl.result_sel = rf_exe_pkg::result_pc;    // Jalr
            17'b000000_?????_10????: ctrl.result_sel = rf_exe_pkg::result_alu;
            17'b000001_1000?_??????: ctrl.result_sel = rf_exe_pkg::result_pc;    // Branch and link
            default: ;
        endcase

        ////////////////////////////////////////////////////////////
        // Coprocessor 0 and usability
        ////////////////////////////////////////////////////////////
        ctrl.mtc0 = ({opcode, rs} == 11'b010000_00100);
        ctrl.rfe  = ({opcode, instr[25], funct} == 13'b010000_1_010000);

        if (opcode[5:2] == 4'b0100) begin
            if (int'(cop_sel) >= cop_count) begin
                ctrl.cop_unusable = 1'b1;       // No such coprocessor
            end else if (!cfg.cop_usable[cop_sel] && !(cop_sel == 2'd0 && cfg.kernel_mode)) begin
                ctrl.cop_unusable = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/issue_hold_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module issue_hold_ctrl (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     rf_valid,
    input  wire rf_exe_pkg::instr_t rf_instruction,
    input  wire [31:0]              rf_pc,
    input  wire                     rf_kill,
    input  wire                     exe_busy,
    input  wire                     muldiv,
    output rf_exe_pkg::instr_t      cur_instr,
    output logic [31:0]             cur_pc,
    output logic                    cur_valid,
    output logic                    rf_stall
);

    logic               held;
    rf_exe_pkg::instr_t hold_instr;
    logic [31:0]        hold_pc;

    // Held copy has priority over the input port
    assign cur_valid = held | rf_valid;
    assign cur_instr = held ? hold_instr : rf_instruction;
    assign cur_pc    = held ? hold_pc : rf_pc;

    // Only muldiv class waits for the unit
    assign rf_stall = cur_valid & muldiv & exe_busy;

    ////////////////////////////////////////////////////////////
    // Hold register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held <= 1'b0;
        end else begin
            held <= rf_stall & ~rf_kill;        // Drop on release or kill
        end
    end

    always_ff @(posedge clk) begin
        if (rf_stall && !held) begin            // First stalled cycle
            hold_instr <= rf_instruction;
            hold_pc    <= rf_pc;
        end
    end

endmodule

`default_nettype wire

// File: design/rf_exe_controller.sv
`timescale 1ns/1ps
`default_nettype none

module rf_exe_controller #(
    parameter int cop_count = 3
) (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     rf_valid,
    input  wire rf_exe_pkg::instr_t rf_instruction,
    input  wire [31:0]              rf_pc,
    input  wire                     rf_kill,
    input  wire                     exe_busy,
    input  wire                     cfg_write,
    input  wire rf_exe_pkg::cfg_t   cfg_data,
    output logic                    rf_stall,
    output rf_exe_pkg::reg_idx_t    rf_address_a,
    output rf_exe_pkg::reg_idx_t    rf_address_b,
    output logic                    exe_valid,
    output rf_exe_pkg::exe_bundle_t exe_out
);

    rf_exe_pkg::cfg_t        cfg;
    rf_exe_pkg::instr_t      cur_instr;
    logic [31:0]             cur_pc;
    logic                    cur_valid;
    rf_exe_pkg::exe_ctrl_t   ctrl;
    logic                    muldiv;
    rf_exe_pkg::exe_bundle_t issue_bundle;
    logic [5:0]              opcode;

    assign opcode       = cur_instr[rf_exe_pkg::opcode_hi:rf_exe_pkg::opcode_lo];
    assign rf_address_a = cur_instr[rf_exe_pkg::rs_hi:rf_exe_pkg::rs_lo];
    assign rf_address_b = cur_instr[rf_exe_pkg::rt_hi:rf_exe_pkg::rt_lo];

    ////////////////////////////////////////////////////////////
    // Issue bundle
    ////////////////////////////////////////////////////////////

    always_comb begin
        issue_bundle.ctrl = ctrl;
        issue_bundle.imm  = cur_instr[rf_exe_pkg::imm_hi:rf_exe_pkg::imm_lo];
        issue_bundle.pc   = cur_pc;
        if (opcode == 6'b000000) begin
            issue_bundle.dest = cur_instr[rf_exe_pkg::rd_hi:rf_exe_pkg::rd_lo];
        end else if (opcode == 6'b000011 || (opcode == 6'b000001 && rf_address_b[4])) begin
            issue_bundle.dest = 5'd31;          // Link register
        end else begin
            issue_bundle.dest = rf_address_b;
        end
    end

    cop_config_regs #(
        .cop_count (cop_count)
    ) u_cop_config_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_write (cfg_write),
        .cfg_data  (cfg_data),
        .cfg       (cfg)
    );

    issue_hold_ctrl u_issue_hold_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .rf_valid       (rf_valid),
        .rf_instruction (rf_instruction),
        .rf_pc          (rf_pc),
        .rf_kill        (rf_kill),
        .exe_busy       (exe_busy),
        .muldiv         (muldiv),
        .cur_instr      (cur_instr),
        .cur_pc         (cur_pc),
        .cur_valid      (cur_valid),
        .rf_stall       (rf_stall)
    );

    instr_decoder #(
        .cop_count (cop_count)
    ) u_instr_decoder (
        .instr  (cur_instr),
        .cfg    (cfg),
        .ctrl   (ctrl),
        .muldiv (muldiv)
    );

    exe_issue_reg u_exe_issue_reg (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (cur_valid & ~rf_stall),
        .kill      (rf_kill),
        .bundle_in (issue_bundle),
        .exe_valid (exe_valid),
        .exe_out   (exe_out)
    );

endmodule

`default_nettype wire

// File: design/rf_exe_pkg.sv
`default_nettype none

package rf_exe_pkg;

    ////////////////////////////////////////////////////////////
    // Instruction field positions
    ////////////////////////////////////////////////////////////

    localparam int opcode_hi = 31;
    localparam int opcode_lo = 26;
    localparam int rs_hi     = 25;
    localparam int rs_lo     = 21;
    localparam int rt_hi     = 20;
    localparam int rt_lo     = 16;
    localparam int rd_hi     = 15;
    localparam int rd_lo     = 11;
    localparam int shamt_hi  = 10;
    localparam int shamt_lo  = 6;
    localparam int funct_hi  = 5;
    localparam int funct_lo  = 0;
    localparam int imm_hi    = 25;      // Jump target width, covers the 16 bit immediate too
    localparam int imm_lo    = 0;

    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_idx_t;

    ////////////////////////////////////////////////////////////
    // Execute stage selects
    ////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        alu_none = 4'd0,
        alu_add  = 4'd1,
        alu_sub  = 4'd2,
        alu_slt  = 4'd3,
        alu_and  = 4'd4,
        alu_or   = 4'd5,
        alu_xor  = 4'd6,
        alu_nor  = 4'd7,
        alu_lui  = 4'd8
    } alu_op_e;

    typedef enum logic [2:0] {
        branch_none     = 3'd0,
        branch_jump     = 3'd1,
        branch_jump_reg = 3'd2,
        branch_eq       = 3'd3,
        branch_neq      = 3'd4,
        branch_lez      = 3'd5,
        branch_gz       = 3'd6,
        branch_lz       = 3'd7
    } branch_op_e;

    typedef enum logic [4:0] {
        load_none  = 5'd0,
        load_ubyte = 5'd1,
        load_sbyte = 5'd2,
        load_uhalf = 5'd3,
        load_shalf = 5'd4,
        load_word  = 5'd5,
        load_lwl   = 5'd6,
        load_lwr   = 5'd7
    } load_op_e;

    typedef enum logic [4:0] {
        store_none = 5'd0,
        store_byte = 5'd1,
        store_half = 5'd2,
        store_word = 5'd3
    } store_op_e;

    typedef enum logic [2:0] {
        shift_none = 3'd0,
        shift_sll  = 3'd1,
        shift_srl  = 3'd2,
        shift_sra  = 3'd3,
        shift_sllv = 3'd4,
        shift_srlv = 3'd5,
        shift_srav = 3'd6
    } shift_op_e;

    typedef enum logic [3:0] {
        result_none  = 4'd0,
        result_alu   = 4'd1,
        result_shift = 4'd2,
        result_load  = 4'd3,
        result_pc    = 4'd4     // Link address
    } result_sel_e;

    ////////////////////////////////////////////////////////////
    // Bundles
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        alu_op_e     alu_op;
        branch_op_e  branch_op;
        load_op_e    load_op;
        store_op_e   store_op;
        shift_op_e   shift_op;
        result_sel_e result_sel;
        logic        shift_imm;     // Shift amount from shamt
        logic        signed_alu;
        logic        mthi;
        logic        mtlo;
        logic        mult;
        logic        multu;
        logic        div;
        logic        divu;
        logic        load;
        logic        store;
        logic        mtc0;
        logic        rfe;
        logic        cop_unusable;
    } exe_ctrl_t;

    typedef struct packed {
        logic       kernel_mode;
        logic [3:0] cop_usable;     // One bit per coprocessor
    } cfg_t;

    typedef struct packed {
        exe_ctrl_t   ctrl;
        logic [25:0] imm;
        logic [31:0] pc;
        reg_idx_t    dest;
    } exe_bundle_t;

endpackage

`default_nettype wire

// File: tests/decode_vectors.svh
task automatic load_decode_table();
    // Columns: name, instruction word, random fill mask, alu, branch, load, store, shift,
    // result, flags {shift_imm signed mthi mtlo mult multu div divu load store mtc0 rfe
    // cop_unusable}, dest

    // ALU immediate forms, rs 9 rt 10
    add_row("lui", 32'h3c0a0000, 32'h0000ffff, 8, 0, 0, 0, 0, 1, 13'b0000000000000, 10);
    add_row("addi", 32'h212a0000, 32'h0000ffff, 1, 0, 0, 0, 0, 1, 13'b0100000000000, 10);
    add_row("slti", 32'h292a0000, 32'h0000ffff, 3, 0, 0, 0, 0, 1, 13'b0100000000000, 10);
    add_row("andi", 32'h312a0000, 32'h0000ffff, 4, 0, 0, 0, 0, 1, 13'b0000000000000, 10);
    add_row("ori", 32'h352a0000, 32'h0000ffff, 5, 0, 0, 0, 0, 1, 13'b0000000000000, 10);
    add_row("xori", 32'h392a0000, 32'h0000ffff, 6, 0, 0, 0, 0, 1, 13'b0000000000000, 10);

    // SPECIAL ALU, rd 11
    add_row("add", 32'h012a5820, 32'h00000000, 1, 0, 0, 0, 0, 1, 13'b0100000000000, 11);
    add_row("subu", 32'h012a5823, 32'h00000000, 2, 0, 0, 0, 0, 1, 13'b0000000000000, 11);
    add_row("and", 32'h012a5824, 32'h00000000, 4, 0, 0, 0, 0, 1, 13'b0000000000000, 11);
    add_row("or", 32'h012a5825, 32'h00000000, 5, 0, 0, 0, 0, 1, 13'b0000000000000, 11);
    add_row("xor", 32'h012a5826, 32'h00000000, 6, 0, 0, 0, 0, 1, 13'b0000000000000, 11);
    add_row("nor", 32'h012a5827, 32'h00000000, 7, 0, 0, 0, 0, 1, 13'b0000000000000, 11);
    add_row("slt", 32'h012a582a, 32'h00000000, 3, 0, 0, 0, 0, 1, 13'b0100000000000, 11);

    // Jumps and branches
    add_row("j", 32'h08000000, 32'h0000ffff, 0, 1, 0, 0, 0, 0, 13'b0000000000000, 0);
    add_row("jal", 32'h0c000000, 32'h03ffffff, 0, 1, 0, 0, 0, 4, 13'b0000000000000, 31);
    add_row("jr", 32'h01200008, 32'h00000000, 0, 2, 0, 0, 0, 0, 13'b0000000000000, 0);
    add_row("jalr", 32'h0120f809, 32'h00000000, 0, 2, 0, 0, 0, 4, 13'b0000000000000, 31);
    add_row("beq", 32'h112a0000, 32'h0000ffff, 0, 3, 0, 0, 0, 0, 13'b0000000000000, 10);
    add_row("bne", 32'h152a0000, 32'h0000ffff, 0, 4, 0, 0, 0, 0, 13'b0000000000000, 10);
    add_row("blez", 32'h19200000, 32'h0000ffff, 0, 5, 0, 0, 0, 0, 13'b0000000000000, 0);
    add_row("bgtz", 32'h1d200000, 32'h0000ffff, 0, 6, 0, 0, 0, 0, 13'b0000000000000, 0);
    add_row("bltz", 32'h05200000, 32'h0000ffff, 0, 7, 0, 0, 0, 0, 13'b0000000000000, 0);
    add_row("bgezal", 32'h05310000, 32'h0000ffff, 0, 6, 0, 0, 0, 4, 13'b0000000000000, 31);

    // Loads and stores
    add_row("lb", 32'h812a0000, 32'h0000ffff, 0, 0, 2, 0, 0, 3, 13'b0000000010000, 10);
    add_row("lbu", 32'h912a0000, 32'h0000ffff, 0, 0, 1, 0, 0, 3, 13'b0000000010000, 10);
    add_row("lh", 32'h852a0000, 32'h0000ffff, 0, 0, 4, 0, 0, 3, 13'b0000000010000, 10);
    add_row("lhu", 32'h952a0000, 32'h0000ffff, 0, 0, 3, 0, 0, 3, 13'b0000000010000, 10);
    add_row("lw", 32'h8d2a0000, 32'h0000ffff, 0, 0, 5, 0, 0, 3, 13'b0000000010000, 10);
    add_row("lwl", 32'h892a0000, 32'h0000ffff, 0, 0, 6, 0, 0, 3, 13'b0000000010000, 10);
    add_row("lwr", 32'h992a0000, 32'h0000ffff, 0, 0, 7, 0, 0, 3, 13'b0000000010000, 10);
    add_row("sb", 32'ha12a0000, 32'h0000ffff, 0, 0, 0, 1, 0, 0, 13'b0000000001000, 10);
    add_row("sh", 32'ha52a0000, 32'h0000ffff, 0, 0, 0, 2, 0, 0, 13'b0000000001000, 10);
    add_row("sw", 32'had2a0000, 32'h0000ffff, 0, 0, 0, 3, 0, 0, 13'b0000000001000, 10);

    // Shifts, shamt 5 on the immediate forms
    add_row("sll", 32'h000a5940, 32'h00000000, 0, 0, 0, 0, 1, 2, 13'b1000000000000, 11);
    add_row("srl", 32'h000a5942, 32'h00000000, 0, 0, 0, 0, 2, 2, 13'b1000000000000, 11);
    add_row("sra", 32'h000a5943, 32'h00000000, 0, 0, 0, 0, 3, 2, 13'b1000000000000, 11);
    add_row("sllv", 32'h012a5804, 32'h00000000, 0, 0, 0, 0, 4, 2, 13'b0000000000000, 11);
    add_row("srlv", 32'h012a5806, 32'h00000000, 0, 0, 0, 0, 5, 2, 13'b0000000000000, 11);
    add_row("srav", 32'h012a5807, 32'h00000000, 0, 0, 0, 0, 6, 2, 13'b0000000000000, 11);

    // HI/LO and multiply/divide
    add_row("mthi", 32'h01200011, 32'h00000000, 0, 0, 0, 0, 0, 0, 13'b0010000000000, 0);
    add_row("mtlo", 32'h01200013, 32'h00000000, 0, 0, 0, 0, 0, 0, 13'b0001000000000, 0);
    add_row("mult", 32'h012a0018, 32'h00000000, 0, 0, 0, 0, 0, 0, 13'b0000100000000, 0);
    add_row("multu", 32'h012a0019, 32'h00000000, 0, 0, 0, 0, 0, 0, 13'b0000010000000, 0);
    add_row("div", 32'h012a001a, 32'h00000000, 0, 0, 0, 0, 0, 0, 13'b0000001000000, 0);
    add_row("divu", 32'h012a001b, 32'h00000000, 0, 0, 0, 0, 0, 0, 13'b0000000100000, 0);

    // COP0 in user mode with nothing usable, so both trap
    add_row("mtc0", 32'h408a6000, 32'h00000000, 0, 0, 0, 0, 0, 0, 13'b0000000000101, 10);
    add_row("rfe", 32'h42000010, 32'h00000000, 0, 0, 0, 0, 0, 0, 13'b0000000000011, 0);
endtask

// File: tests/tb_rf_exe_controller.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rf_exe_controller;

    localparam int cop_count = 3;

    logic                    clk;
    logic                    rst_n;
    logic                    rf_valid;
    rf_exe_pkg::instr_t      rf_instruction;
    logic [31:0]             rf_pc;
    logic                    rf_kill;
    logic                    exe_busy;
    logic                    cfg_write;
    rf_exe_pkg::cfg_t        cfg_data;
    logic                    rf_stall;
    rf_exe_pkg::reg_idx_t    rf_address_a;
    rf_exe_pkg::reg_idx_t    rf_address_b;
    logic                    exe_valid;
    rf_exe_pkg::exe_bundle_t exe_out;

    string                 vec_name[$];     // Decode table rows
    rf_exe_pkg::instr_t    vec_word[$];
    logic [31:0]           vec_fill[$];
    rf_exe_pkg::exe_ctrl_t vec_ctrl[$];
    rf_exe_pkg::reg_idx_t  vec_dest[$];

    rf_exe_controller #(
        .cop_count (cop_count)
    ) dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .rf_valid       (rf_valid),
        .rf_instruction (rf_instruction),
        .rf_pc          (rf_pc),
        .rf_kill        (rf_kill),
        .exe_busy       (exe_busy),
        .cfg_write      (cfg_write),
        .cfg_data       (cfg_data),
        .rf_stall       (rf_stall),
        .rf_address_a   (rf_address_a),
        .rf_address_b   (rf_address_b),
        .exe_valid      (exe_valid),
        .exe_out        (exe_out)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    task automatic check(input string name, input logic [127:0] expected,
                         input logic [127:0] actual);
        if (expected !== actual) begin
            $display("Mismatch %s expected %0h actual %0h", name, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "Check failed for %s", name);
        end
    endtask

    task automatic add_row(input string name, input logic [31:0] word, input logic [31:0] fill,
                           input int alu, input int br, input int ld, input int st,
                           input int sh, input int res, input logic [12:0] flags,
                           input int dest);
        vec_name.push_back(name);
        vec_word.push_back(word);
        vec_fill.push_back(fill);
        vec_ctrl.push_back(rf_exe_pkg::exe_ctrl_t'({4'(alu), 3'(br), 5'(ld), 5'(st),
                                                    3'(sh), 4'(res), flags}));
        vec_dest.push_back(5'(dest));
    endtask

    `include "decode_vectors.svh"

    task automatic settle();
        #5;
    endtask

    task automatic idle_inputs();
        rf_valid       = 1'b0;
        rf_kill        = 1'b0;
        rf_instruction = '0;
        rf_pc          = '0;
    endtask

    // One strobe on the falling edge, outputs settled on return
    task automatic present(input rf_exe_pkg::instr_t word, input logic [31:0] pc,
                           input logic kill, input logic busy);
        @(negedge clk);
        rf_valid       = 1'b1;
        rf_instruction = word;
        rf_pc          = pc;
        rf_kill        = kill;
        exe_busy       = busy;
        settle();
    endtask

    task automatic wait_for_valid(input string name, input int limit);
        int cycles;
        cycles = 0;
        @(negedge clk);
        idle_inputs();
        while (!exe_valid) begin
            cycles++;
            if (cycles >= limit) begin
                $display("Timeout: exe_valid never arrived for %s within %0d cycles",
                         name, limit);
                $display("=== FAIL ===");
                $fatal(1, "Timeout waiting for exe_valid");
            end
            @(negedge clk);
            idle_inputs();
        end
    endtask

    task automatic write_config(input rf_exe_pkg::cfg_t value);
        @(negedge clk);
        cfg_write = 1'b1;
        cfg_data  = value;
        @(negedge clk);
        cfg_write = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        rf_exe_pkg::instr_t word;
        logic [31:0]        pc;
        int                 busy_cycles;
        rf_exe_pkg::cfg_t   cfg_list[6];
        logic [3:0]         cop_expect[6];      // Unusable flag per coprocessor, bit z

        void'($urandom(32'h82dcf1ce));
        rst_n     = 1'b0;
        exe_busy  = 1'b0;
        cfg_write = 1'b0;
        cfg_data  = '0;
        idle_inputs();
        load_decode_table();

        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        settle();
        check("reset exe_valid", 128'(0), 128'(exe_valid));
        check("reset rf_stall", 128'(0), 128'(rf_stall));
        check("reset exe_out", 128'(0), 128'(exe_out));

        // Decode table, unit idle
        for (int i = 0; i < vec_name.size(); i++) begin
            word = vec_word[i] | ($urandom() & vec_fill[i]);
            pc   = $urandom() & 32'hfffffffc;
            present(word, pc, 1'b0, 1'b0);
            check($sformatf("%s rs", vec_name[i]), 128'(word[25:21]), 128'(rf_address_a));
            check($sformatf("%s rt", vec_name[i]), 128'(word[20:16]), 128'(rf_address_b));
            check($sformatf("%s stall", vec_name[i]), 128'(0), 128'(rf_stall));
            wait_for_valid(vec_name[i], 1);
            check($sformatf("%s ctrl", vec_name[i]), 128'(vec_ctrl[i]), 128'(exe_out.ctrl));
            check($sformatf("%s imm", vec_name[i]), 128'(word[25:0]), 128'(exe_out.imm));
            check($sformatf("%s pc", vec_name[i]), 128'(pc), 128'(exe_out.pc));
            check($sformatf("%s dest", vec_name[i]), 128'(vec_dest[i]), 128'(exe_out.dest));
        end

        // Multiply parked while the unit is busy
        busy_cycles = 2 + int'($urandom() % 32'd5);
        word = 32'h012a0018 | ($urandom() & 32'h0000f800);
        pc   = $urandom() & 32'hfffffffc;
        present(word, pc, 1'b0, 1'b1);
        check("stall first", 128'(1), 128'(rf_stall));
        for (int c = 1; c < busy_cycles; c++) begin
            @(negedge clk);
            idle_inputs();
            settle();
            check("stall held", 128'(1), 128'(rf_stall));
            check("stall exe_valid", 128'(0), 128'(exe_valid));
            check("stall rs", 128'(word[25:21]), 128'(rf_address_a));
        end
        @(negedge clk);
        exe_busy = 1'b0;
        settle();
        check("stall release", 128'(0), 128'(rf_stall));
        wait_for_valid("stall release", 1);
        check("released mult", 128'(1), 128'(exe_out.ctrl.mult));
        check("released pc", 128'(pc), 128'(exe_out.pc));
        check("released imm", 128'(word[25:0]), 128'(exe_out.imm));

        // Plain ALU op passes a busy unit
        pc = $urandom() & 32'hfffffffc;
        present(32'h012a5820, pc, 1'b0, 1'b1);
        check("busy add stall", 128'(0), 128'(rf_stall));
        wait_for_valid("busy add", 1);
        check("busy add alu", 128'(rf_exe_pkg::alu_add), 128'(exe_out.ctrl.alu_op));
        exe_busy = 1'b0;

        // Kill on a fresh strobe
        word = 32'h212a0000 | ($urandom() & 32'h0000ffff);
        present(word, $urandom() & 32'hfffffffc, 1'b1, 1'b0);
        check("kill stall", 128'(0), 128'(rf_stall));
        @(negedge clk);
        idle_inputs();
        check("kill exe_valid", 128'(0), 128'(exe_valid));
        check("kill exe_out", 128'(0), 128'(exe_out));

        // Kill on a parked multiply
        present(32'h012a0018, $urandom() & 32'hfffffffc, 1'b0, 1'b1);
        @(negedge clk);
        idle_inputs();
        rf_kill = 1'b1;
        settle();
        check("held kill stall", 128'(1), 128'(rf_stall));
        @(negedge clk);
        idle_inputs();
        settle();
        check("held kill drop", 128'(0), 128'(rf_stall));
        check("held kill exe_valid", 128'(0), 128'(exe_valid));
        @(negedge clk);
        exe_busy = 1'b0;
        repeat (3) begin
            @(negedge clk);
            check("held kill no issue", 128'(0), 128'(exe_valid));
        end

        // Coprocessor usability across configurations, three coprocessors present
        cfg_list[0]   = 5'b0_0000;
        cop_expect[0] = 4'b1111;
        cfg_list[1]   = 5'b0_1111;
        cop_expect[1] = 4'b1000;        // COP3 stays unusable
        cfg_list[2]   = 5'b1_0000;
        cop_expect[2] = 4'b1110;        // Kernel unlocks COP0 only
        cfg_list[3]   = 5'b1_1010;
        cop_expect[3] = 4'b1100;
        cfg_list[4]   = 5'b0_0101;
        cop_expect[4] = 4'b1010;
        cfg_list[5]   = 5'b0_1110;
        cop_expect[5] = 4'b1001;
        for (int k = 0; k < 6; k++) begin
            write_config(cfg_list[k]);
            for (int z = 0; z < 4; z++) begin
                if (z == 0) begin
                    word = 32'h408a0000 | ($urandom() & 32'h0000f800);  // Mtc0
                end else begin
                    word = 32'h40000000 | (32'(z) << 26) | ($urandom() & 32'h03ffffff);
                end
                present(word, $urandom() & 32'hfffffffc, 1'b0, 1'b0);
                wait_for_valid($sformatf("cop%0d cfg %h", z, cfg_list[k]), 1);
                check($sformatf("cop%0d unusable cfg %h", z, cfg_list[k]),
                      128'(cop_expect[k][z]), 128'(exe_out.ctrl.cop_unusable));
                check($sformatf("cop%0d mtc0", z), 128'(z == 0), 128'(exe_out.ctrl.mtc0));
            end
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire
